//--- logic/soc_cfg.svh
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// Number of local SRAM banks behind the decoder
`define SOC_BANK_COUNT 4

// Word address inside one bank, 512 words per bank
`define SOC_BANK_ADDR_BITS 9

// Bus byte address and data widths
`define SOC_WB_ADDR_BITS 28
`define SOC_WB_DATA_BITS 32
`define SOC_WB_SEL_BITS (`SOC_WB_DATA_BITS / 8)

// Device field sits in the top address bits
`define SOC_DEVICE_BITS 4

// Low address bits that pick a byte within a word
`define SOC_WORD_LSB 2

`endif

//--- logic/soc_pkg.sv
`include "soc_cfg.svh"

package soc_pkg;

	// Widths with a meaning on the bus
	typedef logic [`SOC_WB_ADDR_BITS-1:0] wb_addr_t;
	typedef logic [`SOC_WB_DATA_BITS-1:0] wb_data_t;
	typedef logic [`SOC_WB_SEL_BITS-1:0] wb_sel_t;

	// Device number, taken from the top of the address
	typedef logic [`SOC_DEVICE_BITS-1:0] device_idx_t;

	// Word index inside one bank
	typedef logic [`SOC_BANK_ADDR_BITS-1:0] bank_word_t;

	// Controller to device, held until ack or err
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		wb_sel_t sel;
		wb_addr_t adr;
		wb_data_t dat;
	} wb_req_t;

	// Device to controller
	typedef struct packed {
		logic ack;
		logic err;
		wb_data_t dat;
	} wb_rsp_t;

	// Error responder for unmapped device numbers
	typedef enum logic {
		ERR_IDLE,
		ERR_RESPOND
	} err_state_t;

	// Device field of a bus address
	function automatic device_idx_t adr_device(input wb_addr_t adr);
		return adr[`SOC_WB_ADDR_BITS-1 -: `SOC_DEVICE_BITS];
	endfunction

	// Word index of a bus address, bits above it alias
	function automatic bank_word_t adr_word(input wb_addr_t adr);
		return adr[`SOC_WORD_LSB +: `SOC_BANK_ADDR_BITS];
	endfunction

endpackage

//--- logic/wb_device_decoder.sv
`timescale 1ns/1ps

`include "soc_cfg.svh"

module wb_device_decoder (
	input  logic                  wb_clk_i,
	input  logic                  rst_i,
	input  soc_pkg::wb_req_t      req_i,
	output soc_pkg::wb_req_t      bank_req_o [0:`SOC_BANK_COUNT-1],
	output soc_pkg::device_idx_t  dev_sel_o,
	output soc_pkg::wb_rsp_t      err_rsp_o
);

	import soc_pkg::*;

	device_idx_t dev;
	logic [`SOC_BANK_COUNT-1:0] bank_hit;
	logic [`SOC_BANK_COUNT-1:0] bank_stb;
	logic mapped;
	logic strobe;
	err_state_t err_state;
	err_state_t err_state_next;

	assign dev = adr_device(req_i.adr);
	assign strobe = req_i.cyc && req_i.stb;

	// One compare per bank
	always_comb begin
		for (int i = 0; i < `SOC_BANK_COUNT; i++) begin
			bank_hit[i] = (dev == device_idx_t'(i));
		end
	end

	assign mapped = |bank_hit;

	// Only the hit bank sees cyc and stb
	always_comb begin
		for (int i = 0; i < `SOC_BANK_COUNT; i++) begin
			bank_req_o[i] = req_i;
			bank_req_o[i].cyc = req_i.cyc && bank_hit[i];
			bank_req_o[i].stb = req_i.stb && bank_hit[i];
		end
	end

	genvar g;
	generate
		for (g = 0; g < `SOC_BANK_COUNT; g++) begin : g_stb
			assign bank_stb[g] = bank_req_o[g].cyc && bank_req_o[g].stb;
		end
	endgenerate

	assign dev_sel_o = dev;

	// Error responder answers one cycle after the strobe like a bank
	always_comb begin
		err_state_next = err_state;
		case (err_state)
			ERR_IDLE: begin
				if (strobe && !mapped)
					err_state_next = ERR_RESPOND;
			end
			ERR_RESPOND: begin
				// No second err for the held strobe
				err_state_next = ERR_IDLE;
			end
			default: begin
				err_state_next = ERR_IDLE;
			end
		endcase
	end

	always_ff @(posedge wb_clk_i) begin
		if (rst_i)
			err_state <= ERR_IDLE;
		else
			err_state <= err_state_next;
	end

	assign err_rsp_o.ack = 1'b0;
	assign err_rsp_o.err = (err_state == ERR_RESPOND);
	assign err_rsp_o.dat = '0;

	// Unmapped request stays held through the err cycle
	a_err_no_bank_strobe: assert property (
		@(posedge wb_clk_i) disable iff (rst_i)
		err_rsp_o.err |-> (strobe && bank_stb == '0)
	) else $error("err answered while a bank is strobed or the strobe dropped");

endmodule

//--- logic/sram_bank.sv
`timescale 1ns/1ps

`include "soc_cfg.svh"

module sram_bank (
	input  logic             wb_clk_i,
	input  logic             rst_i,
	input  soc_pkg::wb_req_t req_i,
	output soc_pkg::wb_rsp_t rsp_o
);

	import soc_pkg::*;

	// 32x512 storage like the SRAM macro
	wb_data_t mem [0:(1 << `SOC_BANK_ADDR_BITS)-1];

	bank_word_t word_idx;
	wb_data_t cur_word;
	wb_data_t new_word;
	logic accept;
	logic ack_q;
	wb_data_t dat_q;

	// Bits above the word index are ignored here
	assign word_idx = adr_word(req_i.adr);

	// The ack cycle blocks a second accept of a held strobe
	assign accept = req_i.cyc && req_i.stb && !ack_q;

	assign cur_word = mem[word_idx];

	// Byte lane merge
	always_comb begin
		new_word = cur_word;
		for (int lane = 0; lane < `SOC_WB_SEL_BITS; lane++) begin
			if (req_i.we && req_i.sel[lane])
				new_word[lane*8 +: 8] = req_i.dat[lane*8 +: 8];
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (accept && req_i.we)
			mem[word_idx] <= new_word;
	end

	// Read data shows the word after this edge's write
	always_ff @(posedge wb_clk_i) begin
		if (accept)
			dat_q <= new_word;
	end

	always_ff @(posedge wb_clk_i) begin
		if (rst_i)
			ack_q <= 1'b0;
		else
			ack_q <= accept;
	end

	assign rsp_o.ack = ack_q;
	assign rsp_o.err = 1'b0;
	assign rsp_o.dat = dat_q;

	// Controller keeps the strobe up until it samples the ack
	a_ack_with_strobe: assert property (
		@(posedge wb_clk_i) disable iff (rst_i)
		ack_q |-> (req_i.cyc && req_i.stb)
	) else $error("bank ack after the strobe was dropped");

endmodule

//--- logic/wb_response_mux.sv
`timescale 1ns/1ps

`include "soc_cfg.svh"

module wb_response_mux (
	input  soc_pkg::wb_rsp_t     bank_rsp_i [0:`SOC_BANK_COUNT-1],
	input  soc_pkg::wb_rsp_t     err_rsp_i,
	input  soc_pkg::device_idx_t dev_sel_i,
	output soc_pkg::wb_rsp_t     rsp_o
);

	import soc_pkg::*;

	logic ack_any;
	logic err_any;
	wb_data_t rd_dat;

	always_comb begin
		ack_any = err_rsp_i.ack;
		err_any = err_rsp_i.err;
		rd_dat = '0;
		for (int i = 0; i < `SOC_BANK_COUNT; i++) begin
			ack_any = ack_any | bank_rsp_i[i].ack;
			err_any = err_any | bank_rsp_i[i].err;
			// Address is still held in the ack cycle
			if (dev_sel_i == device_idx_t'(i))
				rd_dat = bank_rsp_i[i].dat;
		end
		if (err_rsp_i.err)
			rd_dat = err_rsp_i.dat;
	end

	assign rsp_o.ack = ack_any;
	assign rsp_o.err = err_any;
	assign rsp_o.dat = rd_dat;

	// Bank ack and decoder err come from different modules
	always_comb begin
		a_ack_err_excl: assert final (!(ack_any && err_any))
			else $error("ack and err high together");
	end

endmodule

//--- logic/soc_mem_top.sv
`timescale 1ns/1ps

`include "soc_cfg.svh"

module soc_mem_top (
	input  logic             wb_clk_i,
	input  logic             rst_i,
	input  soc_pkg::wb_req_t wb_req_i,
	output soc_pkg::wb_rsp_t wb_rsp_o
);

	import soc_pkg::*;

	wb_req_t bank_req [0:`SOC_BANK_COUNT-1];
	wb_rsp_t bank_rsp [0:`SOC_BANK_COUNT-1];
	wb_rsp_t err_rsp;
	device_idx_t dev_sel;

	// Steering and error answer
	wb_device_decoder u_decoder (
		.wb_clk_i  (wb_clk_i),
		.rst_i     (rst_i),
		.req_i     (wb_req_i),
		.bank_req_o(bank_req),
		.dev_sel_o (dev_sel),
		.err_rsp_o (err_rsp)
	);

	// Local memories, one per device number from 0 up
	genvar bank_idx;
	generate
		for (bank_idx = 0; bank_idx < `SOC_BANK_COUNT; bank_idx++) begin : g_bank
			sram_bank u_bank (
				.wb_clk_i(wb_clk_i),
				.rst_i   (rst_i),
				.req_i   (bank_req[bank_idx]),
				.rsp_o   (bank_rsp[bank_idx])
			);
		end
	endgenerate

	// Back to the single controller
	wb_response_mux u_rsp_mux (
		.bank_rsp_i(bank_rsp),
		.err_rsp_i (err_rsp),
		.dev_sel_i (dev_sel),
		.rsp_o     (wb_rsp_o)
	);

endmodule

//--- tb/soc_mem_top_tb.sv
`timescale 1ns/1ps

`include "soc_cfg.svh"

module soc_mem_top_tb;

	import soc_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int DRIVE_DLY = 1;
	localparam int RESET_CYCLES = 8;
	localparam int BANKS = `SOC_BANK_COUNT;
	localparam int DEVICES = 1 << `SOC_DEVICE_BITS;
	localparam int BANK_WORDS = 1 << `SOC_BANK_ADDR_BITS;
	localparam int BANK_SEL_BITS = $clog2(BANKS);
	localparam int MODEL_WORDS = BANKS * BANK_WORDS;
	localparam int ALIAS_BITS = `SOC_WB_ADDR_BITS - `SOC_DEVICE_BITS
		- `SOC_BANK_ADDR_BITS - `SOC_WORD_LSB;
	localparam int N_RANDOM = 2000;
	localparam int RSP_LIMIT = 8;
	// Fill and sweep touch every word once, a random op is at most three transfers
	localparam int N_XFERS = 2 * MODEL_WORDS + 3 * N_RANDOM;
	localparam int WATCHDOG_NS = (N_XFERS * 4 + RESET_CYCLES) * CLK_PERIOD;

	typedef logic [BANK_SEL_BITS+`SOC_BANK_ADDR_BITS-1:0] model_idx_t;
	typedef logic [ALIAS_BITS-1:0] alias_t;

	logic wb_clk_i;
	logic rst_i;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;
	integer seed;
	wb_data_t model [0:MODEL_WORDS-1];
	int write_count;
	int read_count;
	int unmapped_count;

	soc_mem_top uut (
		.wb_clk_i(wb_clk_i),
		.rst_i   (rst_i),
		.wb_req_i(wb_req),
		.wb_rsp_o(wb_rsp)
	);

	initial begin
		wb_clk_i = 1'b0;
		forever #(CLK_PERIOD / 2) wb_clk_i = ~wb_clk_i;
	end

	function automatic model_idx_t model_index(input int bank, input bank_word_t word);
		return {bank[BANK_SEL_BITS-1:0], word};
	endfunction

	// Bank number high, word index in the middle, a word-dependent low byte
	function automatic wb_data_t fill_word(input int bank, input bank_word_t word);
		return {4'hA, bank[3:0], 7'h00, word, word[7:0] ^ 8'h5C};
	endfunction

	function automatic wb_addr_t make_addr(input device_idx_t dev, input bank_word_t word,
			input alias_t alias_bits);
		return {dev, alias_bits, word, {`SOC_WORD_LSB{1'b0}}};
	endfunction

	function automatic wb_data_t merge_bytes(input wb_data_t old_word, input wb_data_t wdat,
			input wb_sel_t sel);
		wb_data_t merged;
		merged = old_word;
		for (int lane = 0; lane < `SOC_WB_SEL_BITS; lane++) begin
			if (sel[lane])
				merged[lane*8 +: 8] = wdat[lane*8 +: 8];
		end
		return merged;
	endfunction

	function automatic wb_rsp_t rsp_kind(input logic ack, input logic err);
		wb_rsp_t kind;
		kind.ack = ack;
		kind.err = err;
		kind.dat = '0;
		return kind;
	endfunction

	task automatic report_error(input string msg);
		$display("[ERROR] %0t ns: %s", $time, msg);
		$display(">>> FAIL");
		$fatal(1, "stopping at first mismatch");
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1, "run aborted");
	endtask

	task automatic check_rsp_data(input wb_data_t got, input wb_data_t exp, input string what);
		if (got !== exp)
			report_error($sformatf("%s: data %h, expected %h", what, got, exp));
	endtask

	// Only the ack and err bits are compared here
	task automatic check_rsp_kind(input wb_rsp_t got, input wb_rsp_t exp, input string what);
		if (got.ack !== exp.ack || got.err !== exp.err)
			report_error($sformatf("%s: ack=%b err=%b, expected ack=%b err=%b",
				what, got.ack, got.err, exp.ack, exp.err));
	endtask

	// Starts one cycle after a drive point with stb low, ends the same way
	task automatic bus_transfer(input logic we, input wb_addr_t adr, input wb_sel_t sel,
			input wb_data_t wdat, output wb_rsp_t rsp);
		int waited;
		logic seen;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we = we;
		wb_req.sel = sel;
		wb_req.adr = adr;
		wb_req.dat = wdat;
		waited = 0;
		seen = 1'b0;
		while (!seen) begin
			@(posedge wb_clk_i);
			#DRIVE_DLY;
			waited++;
			if (wb_rsp.ack || wb_rsp.err)
				seen = 1'b1;
			else if (waited >= RSP_LIMIT)
				abort_run($sformatf("No ack or err within %0d cycles for address %h",
					RSP_LIMIT, adr));
		end
		if (waited != 1)
			report_error($sformatf("response %0d cycles after strobe, expected 1", waited));
		rsp = wb_rsp;
		// Strobe held over the ack cycle must not get a second answer
		@(posedge wb_clk_i);
		#DRIVE_DLY;
		check_rsp_kind(wb_rsp, rsp_kind(1'b0, 1'b0), "cycle after response");
		wb_req.cyc = 1'b0;
		wb_req.stb = 1'b0;
		wb_req.we = 1'b0;
		@(posedge wb_clk_i);
		#DRIVE_DLY;
		check_rsp_kind(wb_rsp, rsp_kind(1'b0, 1'b0), "stb low");
	endtask

	task automatic write_word(input int bank, input bank_word_t word, input alias_t alias_bits,
			input wb_sel_t sel, input wb_data_t wdat);
		wb_rsp_t rsp;
		model_idx_t idx;
		idx = model_index(bank, word);
		bus_transfer(1'b1, make_addr(device_idx_t'(bank), word, alias_bits), sel, wdat, rsp);
		check_rsp_kind(rsp, rsp_kind(1'b1, 1'b0), "write");
		model[idx] = merge_bytes(model[idx], wdat, sel);
		write_count++;
	endtask

	task automatic read_expect(input int bank, input bank_word_t word, input alias_t alias_bits,
			input string what);
		wb_rsp_t rsp;
		bus_transfer(1'b0, make_addr(device_idx_t'(bank), word, alias_bits), '1, '0, rsp);
		check_rsp_kind(rsp, rsp_kind(1'b1, 1'b0), what);
		check_rsp_data(rsp.dat, model[model_index(bank, word)], what);
		read_count++;
	endtask

	task automatic random_op();
		logic [31:0] r;
		logic do_write;
		int dev_num;
		int other;
		bank_word_t word;
		alias_t alias_a;
		alias_t alias_b;
		wb_sel_t sel;
		wb_data_t wdat;
		wb_rsp_t rsp;
		r = $random(seed);
		do_write = r[0];
		// Roughly one in eight goes to an unmapped device
		if (r[3:1] != 3'd7)
			dev_num = int'(r[7:4]) % BANKS;
		else
			dev_num = BANKS + int'(r[15:8]) % (DEVICES - BANKS);
		other = (dev_num + 1 + int'(r[23:16]) % (BANKS - 1)) % BANKS;
		r = $random(seed);
		word = r[`SOC_BANK_ADDR_BITS-1:0];
		sel = r[31:28];
		alias_a = r[`SOC_BANK_ADDR_BITS +: ALIAS_BITS];
		r = $random(seed);
		alias_b = r[ALIAS_BITS-1:0];
		wdat = $random(seed);
		if (dev_num >= BANKS) begin
			bus_transfer(do_write, make_addr(device_idx_t'(dev_num), word, alias_a), sel, wdat,
				rsp);
			check_rsp_kind(rsp, rsp_kind(1'b0, 1'b1), "unmapped device");
			check_rsp_data(rsp.dat, '0, "unmapped device data");
			unmapped_count++;
		end else begin
			if (do_write)
				write_word(dev_num, word, alias_a, sel, wdat);
			// Read back through another alias of the same word
			read_expect(dev_num, word, alias_b, "read back");
			if (do_write)
				read_expect(other, word, alias_a, "same offset in other bank");
		end
	endtask

	initial begin
		#(WATCHDOG_NS);
		abort_run($sformatf("Watchdog expired after %0d ns, the test did not finish",
			WATCHDOG_NS));
	end

	initial begin
		seed = 32'h39194d4e;
		write_count = 0;
		read_count = 0;
		unmapped_count = 0;
		wb_req = '0;
		rst_i = 1'b1;
		repeat (RESET_CYCLES) @(posedge wb_clk_i);
		#DRIVE_DLY;
		rst_i = 1'b0;
		repeat (2) begin
			@(posedge wb_clk_i);
			#DRIVE_DLY;
			check_rsp_kind(wb_rsp, rsp_kind(1'b0, 1'b0), "idle after reset");
		end

		// Known contents everywhere before random traffic
		for (int b = 0; b < BANKS; b++) begin
			for (int w = 0; w < BANK_WORDS; w++) begin
				write_word(b, bank_word_t'(w), '0, '1, fill_word(b, bank_word_t'(w)));
			end
		end

		repeat (N_RANDOM) random_op();

		// Unmapped transfers must have left every bank untouched
		for (int b = 0; b < BANKS; b++) begin
			for (int w = 0; w < BANK_WORDS; w++) begin
				read_expect(b, bank_word_t'(w), '1, "final sweep");
			end
		end

		$display("%0d writes, %0d reads, %0d unmapped transfers",
			write_count, read_count, unmapped_count);
		$display(">>> PASS");
		$finish;
	end

endmodule

//--- soc_mem_top.f
+incdir+logic
logic/soc_pkg.sv
logic/wb_device_decoder.sv
logic/sram_bank.sv
logic/wb_response_mux.sv
logic/soc_mem_top.sv
tb/soc_mem_top_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the soc_mem_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=soc_mem_top_tb
BUILD_DIR=obj_dir
BIN=sim_bin
LOG=sim.log

verilator --binary --assert \
	-f soc_mem_top.f \
	--top-module "$TOP" \
	--Mdir "$BUILD_DIR" \
	-o "$BIN"
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q -F -x ">>> PASS" "$LOG"; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed, see $LOG"
	exit 1
fi
